// File: src/chiplet_pkg.sv
package chiplet_pkg;

    localparam int NUM_TILES  = 4;
    localparam int NUM_LINKS  = 2;
    localparam int TILE_ID_W  = 2;
    localparam int LINK_LANES = 4;
    localparam int FLIT_W     = 36;
    localparam int FLIT_BEATS = 9;

    // one flit word, seen as header fields by the router and as lane beats by the links.
    typedef union packed {
        struct packed {
            logic [TILE_ID_W-1:0] dest_tile;
            logic [TILE_ID_W-1:0] src_tile;
            logic [31:0]          payload;
        } fields;
        logic [FLIT_BEATS-1:0][LINK_LANES-1:0] beats; // beat 0 is sent first.
    } flit_u;

    // host register byte offsets.
    localparam logic [31:0] REG_TX_DEST   = 32'h0;
    localparam logic [31:0] REG_TX_DATA   = 32'h4;
    localparam logic [31:0] REG_RX_DATA   = 32'h8;
    localparam logic [31:0] REG_RX_STATUS = 32'hC;

endpackage

// File: src/bus_endpoint.sv
`timescale 1ns/1ps

module bus_endpoint import chiplet_pkg::*; #(
    parameter int TILE_ID     = 0,
    parameter int QUEUE_DEPTH = 4,
    parameter int ADDR_WIDTH  = 32,
    parameter int DATA_WIDTH  = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wen,
    input  logic                    ren,
    input  logic [ADDR_WIDTH-1:0]   addr,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] strobe,
    output logic [DATA_WIDTH-1:0]   rdata,
    output logic                    error,
    output logic                    request_stall,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    output flit_u                   tx_flit,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  flit_u                   rx_flit
);
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [TILE_ID_W-1:0]  dest_tile;
    logic                  dest_we, tx_push, rx_pop;
    logic [1:0]            q_push, q_pop, q_full, q_empty; // index 0 is transmit, 1 is receive.
    logic [CNT_W-1:0]      q_count [2];
    flit_u                 q_out [2];
    flit_u                 tx_new;
    logic [DATA_WIDTH-1:0] status;

    assign q_push = {rx_valid && rx_ready, tx_push};
    assign q_pop  = {rx_pop, tx_valid && tx_ready};

    for (genvar q = 0; q < 2; q++) begin : g_queue
        flit_u            mem [QUEUE_DEPTH];
        logic [PTR_W-1:0] wr_ptr, rd_ptr;
        flit_u            din;

        assign din = (q == 0) ? tx_new : rx_flit;

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr     <= '0;
                rd_ptr     <= '0;
                q_count[q] <= '0;
            end else begin
                if (q_push[q])
                    wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (q_pop[q])
                    rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                q_count[q] <= q_count[q] + CNT_W'(q_push[q]) - CNT_W'(q_pop[q]);
            end
        end

        always_ff @(posedge clk) begin
            if (q_push[q]) mem[wr_ptr] <= din;
        end

        assign q_out[q]   = mem[rd_ptr];
        assign q_full[q]  = (q_count[q] == CNT_W'(QUEUE_DEPTH));
        assign q_empty[q] = (q_count[q] == '0);
    end

    assign tx_valid = !q_empty[0];
    assign tx_flit  = q_out[0];
    assign rx_ready = !q_full[1];

    // the host's own tile number goes in as the source.
    always_comb begin
        tx_new.fields.dest_tile = dest_tile;
        tx_new.fields.src_tile  = TILE_ID_W'(TILE_ID);
        tx_new.fields.payload   = wdata[31:0];
    end

    always_comb begin
        status    = '0;
        status[0] = !q_empty[1];
        if (!q_empty[1]) status[2:1] = q_out[1].fields.src_tile;
        status[7:4] = 4'(q_count[1]);
    end

    always_comb begin
        rdata         = '0;
        error         = 1'b0;
        request_stall = 1'b0;
        dest_we       = 1'b0;
        tx_push       = 1'b0;
        rx_pop        = 1'b0;
        if (wen) begin
            case (addr)
                REG_TX_DEST: dest_we = 1'b1;
                REG_TX_DATA: begin
                    if (q_full[0]) request_stall = 1'b1; // host holds the access.
                    else if (strobe != '1) error = 1'b1;
                    else tx_push = 1'b1;
                end
                default: error = 1'b1;
            endcase
        end else if (ren) begin
            case (addr)
                REG_RX_DATA: begin
                    if (q_empty[1]) begin
                        error = 1'b1;
                    end else begin
                        rx_pop = 1'b1;
                        rdata  = DATA_WIDTH'(q_out[1].fields.payload);
                    end
                end
                REG_RX_STATUS: rdata = status;
                default: error = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) dest_tile <= '0;
        else if (dest_we) dest_tile <= wdata[TILE_ID_W-1:0];
    end

    // a flit refused by a full receive queue has to wait at the router, unchanged.
    a_rx_held: assert property (@(posedge clk) disable iff (reset)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_flit));

endmodule

// File: src/link_rx.sv
`timescale 1ns/1ps

module link_rx import chiplet_pkg::*; #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [LINK_LANES-1:0] link_data,
    input  logic                  link_valid,
    output logic                  link_credit,
    output logic                  out_valid,
    input  logic                  out_ready,
    output flit_u                 out_flit
);
    localparam int BEAT_W = $clog2(FLIT_BEATS);
    localparam int PTR_W  = $clog2(BUFFER_SIZE);
    localparam int CNT_W  = $clog2(BUFFER_SIZE + 1);

    logic [BEAT_W-1:0] beat;
    flit_u             shift, assembled;
    flit_u             mem [BUFFER_SIZE];
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push, pop;

    // the last beat goes straight into the buffer with the ones already held.
    always_comb begin
        assembled = shift;
        assembled.beats[FLIT_BEATS-1] = link_data;
    end

    assign push      = link_valid && (beat == BEAT_W'(FLIT_BEATS - 1));
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            beat        <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            link_credit <= 1'b0;
        end else begin
            if (link_valid) beat <= push ? '0 : beat + 1'b1;
            if (push) wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            count       <= count + CNT_W'(push) - CNT_W'(pop);
            link_credit <= pop; // one credit back per freed slot.
        end
    end

    always_ff @(posedge clk) begin
        if (link_valid && !push) shift.beats[beat] <= link_data;
        if (push) mem[wr_ptr] <= assembled;
    end

    // a full buffer at a flit end means the sender spent a credit it did not have.
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> (count != CNT_W'(BUFFER_SIZE)) || pop);

endmodule

// File: src/link_tx.sv
`timescale 1ns/1ps

module link_tx import chiplet_pkg::*; #(
    parameter int BUFFER_SIZE = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  flit_u                 in_flit,
    output logic [LINK_LANES-1:0] link_data,
    output logic                  link_valid,
    input  logic                  link_credit
);
    localparam int BEAT_W = $clog2(FLIT_BEATS);
    localparam int CRED_W = $clog2(BUFFER_SIZE + 1);

    logic              busy;
    logic [BEAT_W-1:0] beat;
    logic [CRED_W-1:0] credits;
    flit_u             flit_q;
    logic              start;

    assign in_ready = !busy && (credits != '0);
    assign start    = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            beat    <= '0;
            credits <= CRED_W'(BUFFER_SIZE);
        end else begin
            // the credit is spent at the start of the flit.
            credits <= credits - CRED_W'(start) + CRED_W'(link_credit);
            if (start) begin
                busy <= 1'b1;
                beat <= '0;
            end else if (busy) begin
                if (beat == BEAT_W'(FLIT_BEATS - 1)) busy <= 1'b0;
                else beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) flit_q <= in_flit;
    end

    assign link_valid = busy;
    assign link_data  = busy ? flit_q.beats[beat] : '0;

    // more credits than buffer slots means the receiver returned one twice.
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CRED_W'(BUFFER_SIZE));

endmodule

// File: src/tile_router.sv
`timescale 1ns/1ps

module tile_router import chiplet_pkg::*; #(
    parameter int TILE_ID = 0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  local_in_valid,
    output logic  local_in_ready,
    input  flit_u local_in_flit,
    input  logic  link0_in_valid,
    output logic  link0_in_ready,
    input  flit_u link0_in_flit,
    input  logic  link1_in_valid,
    output logic  link1_in_ready,
    input  flit_u link1_in_flit,
    output logic  local_out_valid,
    input  logic  local_out_ready,
    output flit_u local_out_flit,
    output logic  link0_out_valid,
    input  logic  link0_out_ready,
    output flit_u link0_out_flit,
    output logic  link1_out_valid,
    input  logic  link1_out_ready,
    output flit_u link1_out_flit
);
    localparam logic [TILE_ID_W-1:0] ME = TILE_ID_W'(TILE_ID);
    // row 0 tiles reach their x neighbour on link 0, row 1 tiles on link 1.
    localparam logic [1:0] X_PORT = ME[1] ? 2'd2 : 2'd1;
    localparam logic [1:0] Y_PORT = ME[1] ? 2'd1 : 2'd2;

    logic [2:0] in_valid, in_ready, out_valid, out_ready, load_ok;
    flit_u      in_flit [3];
    flit_u      out_flit [3];
    logic [1:0] route [3];
    logic [2:0] grant [3];
    logic [1:0] sel [3];
    logic [1:0] last [3];

    assign in_valid   = {link1_in_valid, link0_in_valid, local_in_valid};
    assign in_flit[0] = local_in_flit;
    assign in_flit[1] = link0_in_flit;
    assign in_flit[2] = link1_in_flit;
    assign out_ready  = {link1_out_ready, link0_out_ready, local_out_ready};
    assign load_ok    = ~out_valid | out_ready;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (in_flit[i].fields.dest_tile == ME) route[i] = 2'd0;
            else if (in_flit[i].fields.dest_tile[0] != ME[0]) route[i] = X_PORT;
            else route[i] = Y_PORT;
        end
    end

    // round-robin search starts just after the input granted last time.
    always_comb begin
        int idx;
        for (int o = 0; o < 3; o++) begin
            grant[o] = '0;
            sel[o]   = last[o];
            for (int k = 1; k <= 3; k++) begin
                idx = (int'(last[o]) + k) % 3;
                if (grant[o] == '0 && in_valid[idx] && route[idx] == 2'(o) && load_ok[o]) begin
                    grant[o][idx] = 1'b1;
                    sel[o]        = 2'(idx);
                end
            end
        end
        for (int i = 0; i < 3; i++) in_ready[i] = grant[0][i] | grant[1][i] | grant[2][i];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
            for (int o = 0; o < 3; o++) last[o] <= '0;
        end else begin
            for (int o = 0; o < 3; o++) begin
                if (grant[o] != '0) begin
                    out_valid[o] <= 1'b1;
                    last[o]      <= sel[o];
                end else if (out_ready[o]) begin
                    out_valid[o] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < 3; o++) begin
            if (grant[o] != '0) out_flit[o] <= in_flit[sel[o]];
        end
    end

    assign {link1_in_ready, link0_in_ready, local_in_ready} = in_ready;
    assign local_out_valid = out_valid[0];
    assign local_out_flit  = out_flit[0];
    assign link0_out_valid = out_valid[1];
    assign link0_out_flit  = out_flit[1];
    assign link1_out_valid = out_valid[2];
    assign link1_out_flit  = out_flit[2];

    // a held flit is for this tile exactly when it waits at the local output.
    for (genvar o = 0; o < 3; o++) begin : g_route_chk
        a_route_match: assert property (@(posedge clk) disable iff (reset)
            out_valid[o] |-> ((out_flit[o].fields.dest_tile == ME) == (o == 0)));
    end

endmodule

// File: src/tile.sv
`timescale 1ns/1ps

module tile import chiplet_pkg::*; #(
    parameter int TILE_ID     = 0,
    parameter int BUFFER_SIZE = 8,
    parameter int QUEUE_DEPTH = 4,
    parameter int ADDR_WIDTH  = 32,
    parameter int DATA_WIDTH  = 32
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wen,
    input  logic                                  ren,
    input  logic [ADDR_WIDTH-1:0]                 addr,
    input  logic [DATA_WIDTH-1:0]                 wdata,
    input  logic [DATA_WIDTH/8-1:0]               strobe,
    output logic [DATA_WIDTH-1:0]                 rdata,
    output logic                                  error,
    output logic                                  request_stall,
    input  logic [NUM_LINKS-1:0][LINK_LANES-1:0] link_in_data,
    input  logic [NUM_LINKS-1:0]                  link_in_valid,
    output logic [NUM_LINKS-1:0]                  link_in_credit,
    output logic [NUM_LINKS-1:0][LINK_LANES-1:0] link_out_data,
    output logic [NUM_LINKS-1:0]                  link_out_valid,
    input  logic [NUM_LINKS-1:0]                  link_out_credit
);
    logic                 ep_tx_valid, ep_tx_ready, ep_rx_valid, ep_rx_ready;
    flit_u                ep_tx_flit, ep_rx_flit;
    logic [NUM_LINKS-1:0] rx_valid, rx_ready, tx_valid, tx_ready;
    flit_u                rx_flit [NUM_LINKS];
    flit_u                tx_flit [NUM_LINKS];

    bus_endpoint #(
        .TILE_ID(TILE_ID), .QUEUE_DEPTH(QUEUE_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
    ) u_endpoint (
        .clk, .reset, .wen, .ren, .addr, .wdata, .strobe, .rdata, .error, .request_stall,
        .tx_valid(ep_tx_valid), .tx_ready(ep_tx_ready), .tx_flit(ep_tx_flit),
        .rx_valid(ep_rx_valid), .rx_ready(ep_rx_ready), .rx_flit(ep_rx_flit)
    );

    tile_router #(.TILE_ID(TILE_ID)) u_router (
        .clk, .reset,
        .local_in_valid(ep_tx_valid), .local_in_ready(ep_tx_ready), .local_in_flit(ep_tx_flit),
        .link0_in_valid(rx_valid[0]), .link0_in_ready(rx_ready[0]), .link0_in_flit(rx_flit[0]),
        .link1_in_valid(rx_valid[1]), .link1_in_ready(rx_ready[1]), .link1_in_flit(rx_flit[1]),
        .local_out_valid(ep_rx_valid), .local_out_ready(ep_rx_ready),
        .local_out_flit(ep_rx_flit),
        .link0_out_valid(tx_valid[0]), .link0_out_ready(tx_ready[0]), .link0_out_flit(tx_flit[0]),
        .link1_out_valid(tx_valid[1]), .link1_out_ready(tx_ready[1]), .link1_out_flit(tx_flit[1])
    );

    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_link
        link_rx #(.BUFFER_SIZE(BUFFER_SIZE)) u_rx (
            .clk, .reset,
            .link_data(link_in_data[l]), .link_valid(link_in_valid[l]),
            .link_credit(link_in_credit[l]),
            .out_valid(rx_valid[l]), .out_ready(rx_ready[l]), .out_flit(rx_flit[l])
        );
        link_tx #(.BUFFER_SIZE(BUFFER_SIZE)) u_tx (
            .clk, .reset,
            .in_valid(tx_valid[l]), .in_ready(tx_ready[l]), .in_flit(tx_flit[l]),
            .link_data(link_out_data[l]), .link_valid(link_out_valid[l]),
            .link_credit(link_out_credit[l])
        );
    end

endmodule

// File: src/tile_wrapper.sv
`timescale 1ns/1ps

module tile_wrapper import chiplet_pkg::*; #(
    parameter int BUFFER_SIZE = 8,
    parameter int QUEUE_DEPTH = 4,
    parameter int ADDR_WIDTH  = 32,
    parameter int DATA_WIDTH  = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [NUM_TILES-1:0]    wen,
    input  logic [NUM_TILES-1:0]    ren,
    input  logic [ADDR_WIDTH-1:0]   addr [NUM_TILES],
    input  logic [DATA_WIDTH-1:0]   wdata [NUM_TILES],
    input  logic [DATA_WIDTH/8-1:0] strobe [NUM_TILES],
    output logic [DATA_WIDTH-1:0]   rdata [NUM_TILES],
    output logic [NUM_TILES-1:0]    error,
    output logic [NUM_TILES-1:0]    request_stall
);
    // link l of tile t faces link PEER_LINK[t][l] of tile PEER_TILE[t][l].
    localparam int PEER_TILE [NUM_TILES][NUM_LINKS] = '{'{1, 2}, '{0, 3}, '{0, 3}, '{1, 2}};
    localparam int PEER_LINK [NUM_TILES][NUM_LINKS] = '{'{0, 0}, '{0, 0}, '{1, 1}, '{1, 1}};

    logic [NUM_LINKS-1:0][LINK_LANES-1:0] rx_data [NUM_TILES];
    logic [NUM_LINKS-1:0][LINK_LANES-1:0] tx_data [NUM_TILES];
    logic [NUM_LINKS-1:0]                 rx_valid [NUM_TILES];
    logic [NUM_LINKS-1:0]                 tx_valid [NUM_TILES];
    logic [NUM_LINKS-1:0]                 rx_credit [NUM_TILES];
    logic [NUM_LINKS-1:0]                 tx_credit [NUM_TILES];

    for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
        tile #(
            .TILE_ID(t), .BUFFER_SIZE(BUFFER_SIZE), .QUEUE_DEPTH(QUEUE_DEPTH),
            .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
        ) u_tile (
            .clk, .reset,
            .wen(wen[t]), .ren(ren[t]), .addr(addr[t]), .wdata(wdata[t]),
            .strobe(strobe[t]), .rdata(rdata[t]), .error(error[t]),
            .request_stall(request_stall[t]),
            .link_in_data(rx_data[t]), .link_in_valid(rx_valid[t]),
            .link_in_credit(rx_credit[t]),
            .link_out_data(tx_data[t]), .link_out_valid(tx_valid[t]),
            .link_out_credit(tx_credit[t])
        );

        // the pairing is symmetric, so credits use the same table backwards.
        for (genvar l = 0; l < NUM_LINKS; l++) begin : g_mesh
            assign rx_data[t][l]   = tx_data[PEER_TILE[t][l]][PEER_LINK[t][l]];
            assign rx_valid[t][l]  = tx_valid[PEER_TILE[t][l]][PEER_LINK[t][l]];
            assign tx_credit[t][l] = rx_credit[PEER_TILE[t][l]][PEER_LINK[t][l]];
        end
    end

endmodule

// File: verif/tile_wrapper_tb.sv
`timescale 1ns/1ps

module tile_wrapper_tb import chiplet_pkg::*; ();
    localparam int BUFFER_SIZE = 8;
    localparam int QUEUE_DEPTH = 4;
    // every send and every read counts once, plus the error accesses and the status sweeps.
    localparam int PLANNED_OPS    = 2 * 300 + 2 * NUM_TILES + 10 + 2 * 40 + 4 * NUM_TILES;
    localparam int TIMEOUT_CYCLES = 40 * PLANNED_OPS + 2000;

    logic        clk;
    logic        reset;
    logic [3:0]  wen, ren;
    logic [31:0] addr [NUM_TILES];
    logic [31:0] wdata [NUM_TILES];
    logic [3:0]  strobe [NUM_TILES];
    logic [31:0] rdata [NUM_TILES];
    logic [3:0]  error, request_stall;

    logic [31:0] lfsr_state = 32'h192a_1d6f;
    logic [31:0] model_q [NUM_TILES*NUM_TILES][$]; // indexed by source * NUM_TILES + destination.
    bit          stall_seen;
    bit          sends_done;
    int          cycles;

    tile_wrapper #(.BUFFER_SIZE(BUFFER_SIZE), .QUEUE_DEPTH(QUEUE_DEPTH)) tile_wrapper_inst (
        .clk, .reset, .wen, .ren, .addr, .wdata, .strobe, .rdata, .error, .request_stall
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // galois lfsr, one step for every bit handed out.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int pending(input int d);
        int total;
        int s;
        total = 0;
        for (s = 0; s < NUM_TILES; s++) total += model_q[s*NUM_TILES + d].size();
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // one host access on tile t; it is held for as long as the tile stalls it.
    task automatic bus_access(input int t, input bit write, input logic [31:0] a,
                              input logic [31:0] d, input logic [3:0] s,
                              output logic [31:0] rd, output logic err);
        wen[t]    = write;
        ren[t]    = !write;
        addr[t]   = a;
        wdata[t]  = d;
        strobe[t] = s;
        @(negedge clk);
        while (request_stall[t]) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        rd  = rdata[t];
        err = error[t];
        @(posedge clk);
        #1;
        wen[t] = 1'b0;
        ren[t] = 1'b0;
    endtask

    task automatic send_flit(input int s, input int d, input logic [31:0] payload);
        logic [31:0] rd;
        logic        err;
        bus_access(s, 1'b1, REG_TX_DEST, 32'(d), 4'hF, rd, err);
        check_value("tx_dest_error", 32'(0), 32'(err));
        bus_access(s, 1'b1, REG_TX_DATA, payload, 4'hF, rd, err);
        check_value("tx_data_error", 32'(0), 32'(err));
        model_q[s*NUM_TILES + d].push_back(payload);
    endtask

    // polls until a flit waits at tile t, then checks it against the model queue of its source.
    task automatic read_and_check(input int t, input string name, output int src);
        logic [31:0] rd;
        logic        err;
        logic [31:0] expected;
        int          key;
        bus_access(t, 1'b0, REG_RX_STATUS, '0, '0, rd, err);
        while (rd[0] == 1'b0) bus_access(t, 1'b0, REG_RX_STATUS, '0, '0, rd, err);
        src = int'(rd[2:1]);
        key = src*NUM_TILES + t;
        check_value({name, "_source_pending"}, 32'(1), 32'(model_q[key].size() != 0));
        expected = model_q[key].pop_front();
        bus_access(t, 1'b0, REG_RX_DATA, '0, '0, rd, err);
        check_value({name, "_error"}, 32'(0), 32'(err));
        check_value({name, "_payload"}, expected, rd);
    endtask

    task automatic check_status_zero(input string name);
        logic [31:0] rd;
        logic        err;
        int          t;
        for (t = 0; t < NUM_TILES; t++) begin
            bus_access(t, 1'b0, REG_RX_STATUS, '0, '0, rd, err);
            check_value({name, "_status_error"}, 32'(0), 32'(err));
            check_value({name, "_status"}, 32'(0), rd);
        end
    endtask

    initial begin
        int          s, d, r, e, src, n, t;
        logic [31:0] rd;
        logic        err;
        clk    = 1'b0;
        reset  = 1'b1;
        wen    = '0;
        ren    = '0;
        cycles = 0;
        for (t = 0; t < NUM_TILES; t++) begin
            addr[t]   = '0;
            wdata[t]  = '0;
            strobe[t] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        for (t = 0; t < NUM_TILES; t++) begin
            check_value("reset_error", 32'(0), 32'(error[t]));
            check_value("reset_stall", 32'(0), 32'(request_stall[t]));
        end
        check_status_zero("reset");

        // at most QUEUE_DEPTH flits owed to a tile, so every one of them can land.
        for (n = 0; n < 300; n++) begin
            s = int'(random_bits(2));
            d = int'(random_bits(2));
            while (pending(d) >= QUEUE_DEPTH) read_and_check(d, "random_read", src);
            send_flit(s, d, random_bits(32));
            if (random_bits(1) == 32'(1)) begin
                r = int'(random_bits(2));
                if (pending(r) != 0) read_and_check(r, "random_read", src);
            end
        end
        for (t = 0; t < NUM_TILES; t++) begin
            while (pending(t) != 0) read_and_check(t, "drain_read", src);
        end

        // only the queue from t to itself holds a flit, so the reported source must be t.
        for (t = 0; t < NUM_TILES; t++) begin
            send_flit(t, t, random_bits(32));
            read_and_check(t, "self_send", src);
        end

        e = int'(random_bits(2));
        d = int'(random_bits(2));
        bus_access(e, 1'b1, REG_TX_DEST, 32'(d), 4'hF, rd, err);
        check_value("err_setup", 32'(0), 32'(err));
        bus_access(e, 1'b1, 32'h10, random_bits(32), 4'hF, rd, err);
        check_value("err_unmapped_write", 32'(1), 32'(err));
        bus_access(e, 1'b0, 32'h14, '0, '0, rd, err);
        check_value("err_unmapped_read", 32'(1), 32'(err));
        bus_access(e, 1'b0, REG_TX_DEST, '0, '0, rd, err);
        check_value("err_read_tx_dest", 32'(1), 32'(err));
        bus_access(e, 1'b1, REG_RX_STATUS, random_bits(32), 4'hF, rd, err);
        check_value("err_write_rx_status", 32'(1), 32'(err));
        bus_access(e, 1'b0, REG_RX_DATA, '0, '0, rd, err);
        check_value("err_read_empty", 32'(1), 32'(err));
        bus_access(e, 1'b1, REG_TX_DATA, random_bits(32), 4'b0111, rd, err);
        check_value("err_partial_strobe", 32'(1), 32'(err));
        check_status_zero("err_after");
        // a flit sent by the partial write would arrive ahead of this one on the same path.
        send_flit(e, d, random_bits(32));
        read_and_check(d, "err_marker", src);
        check_status_zero("err_marker");

        s = int'(random_bits(2));
        d = s ^ 3; // the diagonal tile, two hops away.
        stall_seen = 1'b0;
        sends_done = 1'b0;
        fork
            begin
                for (n = 0; n < 40; n++) send_flit(s, d, random_bits(32));
                sends_done = 1'b1;
            end
            begin
                wait (stall_seen || sends_done);
                @(posedge clk);
                #1;
                for (r = 0; r < 40; r++) read_and_check(d, "backpressure", src);
            end
        join
        check_value("bp_stall_seen", 32'(1), 32'(stall_seen));
        check_status_zero("bp_after");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: src.f
src/chiplet_pkg.sv
src/bus_endpoint.sv
src/link_rx.sv
src/link_tx.sv
src/tile_router.sv
src/tile.sv
src/tile_wrapper.sv
verif/tile_wrapper_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tile_wrapper_tb -o tile_wrapper_sim

output=$(./obj_dir/tile_wrapper_sim) || true
echo "$output"
if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1
